/* Makefile */
# Verilator simulation of the eu_ybuf operand buffer
# every variable can be overridden on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= eu_top_tb
FILELIST  ?= eu_ybuf.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# the run fails if the simulator exits with an error or the log holds the fail message
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "SOME TESTS FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* eu_ybuf.f */
source/eu_pkg.sv
source/cache_dp.sv
source/eu_ybuf.sv
source/eu_alu.sv
source/eu_top.sv
tb/eu_top_properties.sv
tb/eu_top_tb.sv

/* source/cache_dp.sv */
`timescale 1ns/1ps
`default_nettype none

// direct-mapped store, slot picked by the low IDX_BITS of the address
// the tag of an entry lives in its top ADDR_WIDTH bits
module cache_dp #(
  parameter int IDX_BITS   = 2,
  parameter int ADDR_WIDTH = 6,
  parameter int DATA_WIDTH = 22
) (
  input  wire logic                  clk,
  input  wire logic                  reset_n,

  // port a: slot check on addra_i, write slot taken from the tag in wdata_i
  input  wire logic [ADDR_WIDTH-1:0] addra_i,
  input  wire logic [DATA_WIDTH-1:0] wdata_i,
  input  wire logic                  wea_i,
  input  wire logic                  clear_i,
  output logic                       wok_o,

  // port b: registered tagged read
  input  wire logic [ADDR_WIDTH-1:0] addrb_i,
  input  wire logic                  reb_i,
  output logic [DATA_WIDTH-1:0]      rdatab_o,
  output logic                       rhitb_o
);

  localparam int SLOTS   = 2**IDX_BITS;
  localparam int TAG_LSB = DATA_WIDTH - ADDR_WIDTH;

  logic [DATA_WIDTH-1:0] mem [SLOTS];
  logic [SLOTS-1:0]      valid_q;

  logic [IDX_BITS-1:0]   idx_a;
  logic [IDX_BITS-1:0]   idx_w;
  logic [IDX_BITS-1:0]   idx_b;
  logic [ADDR_WIDTH-1:0] wtag;

  assign wtag  = wdata_i[DATA_WIDTH-1:TAG_LSB];
  assign idx_a = addra_i[IDX_BITS-1:0];
  assign idx_w = wtag[IDX_BITS-1:0];
  assign idx_b = addrb_i[IDX_BITS-1:0];

  // free slot or same tag already there
  assign wok_o = !valid_q[idx_a] || (mem[idx_a][DATA_WIDTH-1:TAG_LSB] == addra_i);

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      valid_q <= '0;
    end else if (clear_i) begin
      valid_q <= '0;
    end else if (wea_i) begin
      valid_q[idx_w] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wea_i) begin
      mem[idx_w] <= wdata_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      rhitb_o <= 1'b0;
    end else begin
      rhitb_o <= reb_i && valid_q[idx_b] && (mem[idx_b][DATA_WIDTH-1:TAG_LSB] == addrb_i);
    end
  end

  always_ff @(posedge clk) begin
    if (reb_i) begin
      rdatab_o <= mem[idx_b];
    end
  end

endmodule

`default_nettype wire

/* source/eu_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module eu_alu (
  input  wire logic              clk,
  input  wire logic              reset_n,

  input  wire eu_pkg::eu_instr_t instr_i,
  input  wire logic              instr_valid_i,

  output eu_pkg::alu_addr_t      op0_req_addr_o,
  output eu_pkg::alu_addr_t      op1_req_addr_o,
  output logic                   req_valid_o,

  input  wire eu_pkg::eu_data_t  op0_data_i,
  input  wire logic              op0_success_i,
  input  wire eu_pkg::eu_data_t  op1_data_i,
  input  wire logic              op1_success_i,

  output eu_pkg::alu_addr_t      result_addr_o,
  output eu_pkg::eu_data_t       result_data_o,
  output logic                   result_valid_o,
  input  wire logic              result_success_i,

  output eu_pkg::eu_done_t       done_o,
  output logic                   done_valid_o
);

  typedef struct packed {
    eu_pkg::eu_op_e    op;
    eu_pkg::alu_addr_t dst;
    eu_pkg::eu_data_t  imm;
  } s1_t;

  logic                          s1_valid_q;
  s1_t                           s1_q;
  logic                          s2_valid_q;
  eu_pkg::eu_done_t              s2_q;
  eu_pkg::eu_done_t              s2_d;
  logic [2*eu_pkg::DATA_W-1:0]   product;

  // lookups go out straight from the incoming instruction
  assign op0_req_addr_o = instr_i.src0;
  assign op1_req_addr_o = instr_i.src1;
  assign req_valid_o    = instr_valid_i;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else begin
      s1_valid_q <= instr_valid_i;
      s2_valid_q <= s1_valid_q;
    end
  end

  always_ff @(posedge clk) begin
    s1_q.op  <= instr_i.op;
    s1_q.dst <= instr_i.dst;
    s1_q.imm <= instr_i.imm;
    s2_q     <= s2_d;
  end

  // ------------------------------------------------------------------------
  // operand stage
  // ------------------------------------------------------------------------

  assign product = op0_data_i * op1_data_i;

  always_comb begin
    s2_d.dst    = s1_q.dst;
    s2_d.status = eu_pkg::ST_OK;
    unique case (s1_q.op)
      eu_pkg::OP_ADD:   s2_d.data = op0_data_i + op1_data_i;
      eu_pkg::OP_SUB:   s2_d.data = op0_data_i - op1_data_i;
      eu_pkg::OP_MUL:   s2_d.data = product[eu_pkg::DATA_W-1:0];
      eu_pkg::OP_LOADI: s2_d.data = s1_q.imm;
    endcase
    // loadi needs no operands
    if (s1_q.op != eu_pkg::OP_LOADI) begin
      if (!op0_success_i) begin
        s2_d.status = eu_pkg::ST_MISS0;
      end else if (!op1_success_i) begin
        s2_d.status = eu_pkg::ST_MISS1;
      end
    end
    if (s2_d.status != eu_pkg::ST_OK) begin
      s2_d.data = '0;
    end
  end

  // ------------------------------------------------------------------------
  // result stage
  // ------------------------------------------------------------------------

  assign result_addr_o  = s2_q.dst;
  assign result_data_o  = s2_q.data;
  assign result_valid_o = s2_valid_q && (s2_q.status == eu_pkg::ST_OK);

  always_comb begin
    done_o = s2_q;
    if (s2_q.status == eu_pkg::ST_OK && !result_success_i) begin
      done_o.status = eu_pkg::ST_CONFLICT;
    end
  end

  assign done_valid_o = s2_valid_q;

endmodule

`default_nettype wire

/* source/eu_pkg.sv */
`default_nettype none

package eu_pkg;

  // ------------------------------------------------------------------------
  // widths
  // ------------------------------------------------------------------------

  localparam int DATA_W = 16;
  localparam int ADDR_W = 6;

  typedef logic [DATA_W-1:0] eu_data_t;
  typedef logic [ADDR_W-1:0] alu_addr_t;

  // ------------------------------------------------------------------------
  // instruction and completion
  // ------------------------------------------------------------------------

  typedef enum logic [1:0] {
    OP_ADD,
    OP_SUB,
    OP_MUL,
    OP_LOADI
  } eu_op_e;

  // miss0 outranks miss1, which outranks conflict
  typedef enum logic [1:0] {
    ST_OK,
    ST_MISS0,
    ST_MISS1,
    ST_CONFLICT
  } eu_status_e;

  typedef struct packed {
    eu_op_e    op;
    alu_addr_t src0;
    alu_addr_t src1;
    alu_addr_t dst;
    eu_data_t  imm;
  } eu_instr_t;

  typedef struct packed {
    alu_addr_t  dst;
    eu_data_t   data;
    eu_status_e status;
  } eu_done_t;

  // bank payload, tag kept in the top bits as cache_dp expects
  typedef struct packed {
    alu_addr_t tag;
    eu_data_t  data;
  } ybuf_entry_t;

endpackage

`default_nettype wire

/* source/eu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module eu_top #(
  parameter int NUM_IDX_BITS = 2
) (
  input  wire logic              clk,
  input  wire logic              reset_n,
  input  wire eu_pkg::eu_instr_t instr_i,
  input  wire logic              instr_valid_i,
  input  wire logic              swap_i,
  output eu_pkg::eu_done_t       done_o,
  output logic                   done_valid_o
);

  eu_pkg::alu_addr_t op0_req_addr;
  eu_pkg::alu_addr_t op1_req_addr;
  logic              req_valid;
  eu_pkg::eu_data_t  op0_data;
  logic              op0_success;
  eu_pkg::eu_data_t  op1_data;
  logic              op1_success;
  eu_pkg::alu_addr_t result_addr;
  eu_pkg::eu_data_t  result_data;
  logic              result_valid;
  logic              result_success;

  eu_alu eu_alu_inst (
    .clk              (clk),
    .reset_n          (reset_n),
    .instr_i          (instr_i),
    .instr_valid_i    (instr_valid_i),
    .op0_req_addr_o   (op0_req_addr),
    .op1_req_addr_o   (op1_req_addr),
    .req_valid_o      (req_valid),
    .op0_data_i       (op0_data),
    .op0_success_i    (op0_success),
    .op1_data_i       (op1_data),
    .op1_success_i    (op1_success),
    .result_addr_o    (result_addr),
    .result_data_o    (result_data),
    .result_valid_o   (result_valid),
    .result_success_i (result_success),
    .done_o           (done_o),
    .done_valid_o     (done_valid_o)
  );

  eu_ybuf #(
    .NUM_IDX_BITS (NUM_IDX_BITS)
  ) eu_ybuf_inst (
    .clk              (clk),
    .reset_n          (reset_n),
    .op0_req_addr_i   (op0_req_addr),
    .op1_req_addr_i   (op1_req_addr),
    .req_valid_i      (req_valid),
    .op0_data_o       (op0_data),
    .op0_success_o    (op0_success),
    .op1_data_o       (op1_data),
    .op1_success_o    (op1_success),
    .result_addr_i    (result_addr),
    .result_data_i    (result_data),
    .result_valid_i   (result_valid),
    .result_success_o (result_success),
    .swap_i           (swap_i)
  );

endmodule

`default_nettype wire

/* source/eu_ybuf.sv */
`timescale 1ns/1ps
`default_nettype none

module eu_ybuf #(
  parameter int NUM_IDX_BITS = 2
) (
  input  wire logic              clk,
  input  wire logic              reset_n,

  input  wire eu_pkg::alu_addr_t op0_req_addr_i,
  input  wire eu_pkg::alu_addr_t op1_req_addr_i,
  input  wire logic              req_valid_i,

  output eu_pkg::eu_data_t       op0_data_o,
  output logic                   op0_success_o,
  output eu_pkg::eu_data_t       op1_data_o,
  output logic                   op1_success_o,

  input  wire eu_pkg::alu_addr_t result_addr_i,
  input  wire eu_pkg::eu_data_t  result_data_i,
  input  wire logic              result_valid_i,
  output logic                   result_success_o,

  input  wire logic              swap_i
);

  // role_q names the read bank, the other one collects results
  logic role_q;
  logic wr_sel;

  logic                stg_valid_q;
  eu_pkg::ybuf_entry_t stg_q;
  logic                stg_clash;

  eu_pkg::ybuf_entry_t bank_rdata [2];
  logic                bank_hit   [2];
  logic                bank_wok   [2];

  assign wr_sel = ~role_q;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      role_q <= 1'b0;
    end else if (swap_i) begin
      role_q <= ~role_q;
    end
  end

  // ------------------------------------------------------------------------
  // staging register, drains into the write bank one cycle later
  // ------------------------------------------------------------------------

  // a staged entry is not in the bank yet, so check its slot here as well
  assign stg_clash = stg_valid_q &&
                     (stg_q.tag[NUM_IDX_BITS-1:0] == result_addr_i[NUM_IDX_BITS-1:0]) &&
                     (stg_q.tag != result_addr_i);

  assign result_success_o = bank_wok[wr_sel] && !stg_clash;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      stg_valid_q <= 1'b0;
    end else begin
      stg_valid_q <= result_valid_i && result_success_o;
    end
  end

  always_ff @(posedge clk) begin
    if (result_valid_i) begin
      stg_q.tag  <= result_addr_i;
      stg_q.data <= result_data_i;
    end
  end

  // ------------------------------------------------------------------------
  // banks
  // ------------------------------------------------------------------------

  for (genvar b = 0; b < 2; b++) begin : g_bank
    logic is_read;

    assign is_read = (role_q == 1'(b));

    cache_dp #(
      .IDX_BITS   (NUM_IDX_BITS),
      .ADDR_WIDTH (eu_pkg::ADDR_W),
      .DATA_WIDTH ($bits(eu_pkg::ybuf_entry_t))
    ) bank_inst (
      .clk      (clk),
      .reset_n  (reset_n),
      .addra_i  (result_addr_i),
      .wdata_i  (stg_q),
      .wea_i    (stg_valid_q && !is_read),
      // the read bank becomes the write bank at this edge
      .clear_i  (swap_i && is_read),
      .wok_o    (bank_wok[b]),
      .addrb_i  (is_read ? op0_req_addr_i : op1_req_addr_i),
      .reb_i    (req_valid_i),
      .rdatab_o (bank_rdata[b]),
      .rhitb_o  (bank_hit[b])
    );
  end

  assign op0_data_o    = bank_rdata[role_q].data;
  assign op0_success_o = bank_hit[role_q];
  assign op1_data_o    = bank_rdata[wr_sel].data;
  assign op1_success_o = bank_hit[wr_sel];

endmodule

`default_nettype wire

/* tb/eu_top_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module eu_top_properties (
  input wire logic clk,
  input wire logic reset_n,
  input wire logic instr_valid_i,
  input wire logic swap_i,
  input wire logic done_valid_i
);

  // --------------------------------------------------------------------------
  // reset and issue rules
  // --------------------------------------------------------------------------

  a_reset_quiet : assert property (@(posedge clk) !reset_n |=> !done_valid_i)
    else $error("done_valid_o high after a reset edge");

  // banks only swap with the pipeline drained
  a_swap_idle : assert property (@(posedge clk) disable iff (!reset_n)
    swap_i |-> !($past(instr_valid_i, 1) || $past(instr_valid_i, 2) ||
                 $past(instr_valid_i, 3) || $past(instr_valid_i, 4)))
    else $error("swap_i within four cycles of an issued instruction");

  // fixed two cycle latency, both directions
  a_done_latency : assert property (@(posedge clk) disable iff (!reset_n)
    instr_valid_i |-> ##2 done_valid_i)
    else $error("done_valid_o missing two cycles after issue");

  a_done_source : assert property (@(posedge clk) disable iff (!reset_n)
    done_valid_i |-> $past(instr_valid_i, 2))
    else $error("done_valid_o without an instruction two cycles before");

endmodule

bind eu_top eu_top_properties eu_top_properties_inst (
  .clk           (clk),
  .reset_n       (reset_n),
  .instr_valid_i (instr_valid_i),
  .swap_i        (swap_i),
  .done_valid_i  (done_valid_o)
);

`default_nettype wire

/* tb/eu_top_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module eu_top_tb;

  localparam int NUM_IDX_BITS  = 2;
  localparam int SLOTS         = 2**NUM_IDX_BITS;
  localparam int CLK_PERIOD    = 40;
  localparam int TEST_CYCLES   = 160;
  localparam int MARGIN_CYCLES = 40;

  logic              clk;
  logic              reset_n;
  eu_pkg::eu_instr_t instr_i;
  logic              instr_valid_i;
  logic              swap_i;
  eu_pkg::eu_done_t  done_o;
  logic              done_valid_o;

  int seed   = 11620;
  int errors = 0;
  int checks = 0;
  int cyc    = 0;

  // reference banks whose entries become readable from edge m_ready on
  logic              m_valid [2][SLOTS];
  eu_pkg::alu_addr_t m_tag   [2][SLOTS];
  eu_pkg::eu_data_t  m_data  [2][SLOTS];
  int                m_ready [2][SLOTS];
  int                m_role;

  eu_pkg::eu_done_t  want_q [$];
  int                edge_q [$];
  eu_pkg::eu_done_t  last_done;

  eu_top #(
    .NUM_IDX_BITS (NUM_IDX_BITS)
  ) eu_top_inst (
    .clk           (clk),
    .reset_n       (reset_n),
    .instr_i       (instr_i),
    .instr_valid_i (instr_valid_i),
    .swap_i        (swap_i),
    .done_o        (done_o),
    .done_valid_o  (done_valid_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  // rising edge count that places model writes in time
  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  initial begin
    #((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, tests did not finish", cyc);
    $display("SOME TESTS FAILED");
    $finish;
  end

  // --------------------------------------------------------------------------
  // compare tasks
  // --------------------------------------------------------------------------

  task automatic check_flag(input logic got, input logic want, input string what);
    checks++;
    if (got !== want) begin
      errors++;
      $display("Error at %0d ns: %s is %b, expected %b", $time, what, got, want);
    end
  endtask

  task automatic check_status(input eu_pkg::eu_status_e got, input eu_pkg::eu_status_e want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("Error at %0d ns: status %s, expected %s", $time, got.name(), want.name());
    end
  endtask

  task automatic check_done(input eu_pkg::eu_done_t got, input eu_pkg::eu_done_t want);
    checks++;
    if (got.dst !== want.dst || got.data !== want.data) begin
      errors++;
      $display("Error at %0d ns: done dst %h data %h, expected dst %h data %h",
               $time, got.dst, got.data, want.dst, want.data);
    end
    check_status(got.status, want.status);
  endtask

  // --------------------------------------------------------------------------
  // stimulus and model
  // --------------------------------------------------------------------------

  function automatic eu_pkg::eu_data_t rand_data();
    logic [31:0] r;
    r = $random(seed);
    return r[eu_pkg::DATA_W-1:0];
  endfunction

  function automatic eu_pkg::alu_addr_t rand_addr();
    logic [31:0] r;
    r = $random(seed);
    return r[eu_pkg::ADDR_W-1:0];
  endfunction

  function automatic void model_lookup(input int bank, input eu_pkg::alu_addr_t addr,
                                       input int edge_no, output logic hit,
                                       output eu_pkg::eu_data_t data);
    int idx;
    idx  = int'(addr) % SLOTS;
    hit  = m_valid[bank][idx] && (m_tag[bank][idx] == addr) && (edge_no >= m_ready[bank][idx]);
    data = m_data[bank][idx];
  endfunction

  // pops one completion per falling edge while done_valid_o is high
  task automatic collect_done();
    if (done_valid_o === 1'b1) begin
      if (want_q.size() == 0) begin
        errors++;
        $display("done_valid_o went high at %0d ns with no instruction in flight", $time);
      end else begin
        if (cyc + 1 - edge_q[0] != 2) begin
          errors++;
          $display("Error at %0d ns: done after %0d cycles, expected 2",
                   $time, cyc + 1 - edge_q[0]);
        end
        check_done(done_o, want_q[0]);
        last_done = done_o;
        void'(want_q.pop_front());
        void'(edge_q.pop_front());
      end
    end
  endtask

  task automatic step();
    @(negedge clk);
    collect_done();
  endtask

  task automatic issue(input eu_pkg::eu_op_e op, input eu_pkg::alu_addr_t src0,
                       input eu_pkg::alu_addr_t src1, input eu_pkg::alu_addr_t dst,
                       input eu_pkg::eu_data_t imm);
    int               edge_no;
    int               wb;
    int               widx;
    logic             hit0;
    logic             hit1;
    eu_pkg::eu_data_t a;
    eu_pkg::eu_data_t b;
    logic [31:0]      prod;
    eu_pkg::eu_done_t want;
    step();
    instr_i.op    = op;
    instr_i.src0  = src0;
    instr_i.src1  = src1;
    instr_i.dst   = dst;
    instr_i.imm   = imm;
    instr_valid_i = 1'b1;
    edge_no = cyc + 1;
    wb      = 1 - m_role;
    model_lookup(m_role, src0, edge_no, hit0, a);
    model_lookup(wb, src1, edge_no, hit1, b);
    prod        = 32'(a) * 32'(b);
    want.dst    = dst;
    want.status = eu_pkg::ST_OK;
    case (op)
      eu_pkg::OP_ADD: want.data = a + b;
      eu_pkg::OP_SUB: want.data = a - b;
      eu_pkg::OP_MUL: want.data = prod[eu_pkg::DATA_W-1:0];
      default:        want.data = imm;
    endcase
    if (op != eu_pkg::OP_LOADI && !hit0) begin
      want.status = eu_pkg::ST_MISS0;
    end else if (op != eu_pkg::OP_LOADI && !hit1) begin
      want.status = eu_pkg::ST_MISS1;
    end
    if (want.status != eu_pkg::ST_OK) begin
      want.data = '0;
    end else begin
      widx = int'(dst) % SLOTS;
      if (m_valid[wb][widx] && m_tag[wb][widx] != dst) begin
        want.status = eu_pkg::ST_CONFLICT;
      end else begin
        // the write goes through the staging register and is readable four edges after issue
        m_valid[wb][widx] = 1'b1;
        m_tag[wb][widx]   = dst;
        m_data[wb][widx]  = want.data;
        m_ready[wb][widx] = edge_no + 4;
      end
    end
    want_q.push_back(want);
    edge_q.push_back(edge_no);
  endtask

  // drain in-flight results and let the last write land
  task automatic wait_done();
    int n;
    n = 0;
    while (want_q.size() != 0 && n < 8) begin
      step();
      instr_valid_i = 1'b0;
      n++;
    end
    if (want_q.size() != 0) begin
      errors++;
      $display("timed out waiting for done_valid_o, %0d results missing", want_q.size());
      want_q.delete();
      edge_q.delete();
    end
    repeat (2) begin
      step();
      instr_valid_i = 1'b0;
    end
  endtask

  task automatic swap_banks();
    repeat (4) begin
      step();
      instr_valid_i = 1'b0;
    end
    step();
    swap_i = 1'b1;
    m_role = 1 - m_role;
    for (int i = 0; i < SLOTS; i++) begin
      m_valid[1 - m_role][i] = 1'b0;
    end
    step();
    swap_i = 1'b0;
  endtask

  // --------------------------------------------------------------------------
  // directed tests
  // --------------------------------------------------------------------------

  task automatic test_reset_state();
    repeat (3) begin
      step();
      check_flag(done_valid_o, 1'b0, "done_valid_o after reset");
    end
    issue(eu_pkg::OP_ADD, rand_addr(), rand_addr(), rand_addr(), '0);
    issue(eu_pkg::OP_ADD, rand_addr(), rand_addr(), rand_addr(), '0);
    wait_done();
    check_status(last_done.status, eu_pkg::ST_MISS0);
  endtask

  task automatic test_load_forward();
    issue(eu_pkg::OP_LOADI, '0, '0, 6'h04, rand_data());
    issue(eu_pkg::OP_LOADI, '0, '0, 6'h05, rand_data());
    issue(eu_pkg::OP_LOADI, '0, '0, 6'h22, rand_data());
    issue(eu_pkg::OP_LOADI, '0, '0, 6'h33, rand_data());
    wait_done();
    swap_banks();
    // src1 is not in the bank yet right behind the load
    issue(eu_pkg::OP_LOADI, '0, '0, 6'h05, rand_data());
    issue(eu_pkg::OP_SUB, 6'h04, 6'h05, 6'h06, '0);
    wait_done();
    check_status(last_done.status, eu_pkg::ST_MISS1);
    issue(eu_pkg::OP_SUB, 6'h04, 6'h05, 6'h06, '0);
    wait_done();
    check_status(last_done.status, eu_pkg::ST_OK);
  endtask

  task automatic test_swap();
    swap_banks();
    issue(eu_pkg::OP_ADD, 6'h05, 6'h05, 6'h07, '0);
    wait_done();
    check_status(last_done.status, eu_pkg::ST_MISS1);
    issue(eu_pkg::OP_LOADI, '0, '0, 6'h09, rand_data());
    wait_done();
    issue(eu_pkg::OP_ADD, 6'h06, 6'h09, 6'h0a, '0);
    wait_done();
    check_status(last_done.status, eu_pkg::ST_OK);
  endtask

  task automatic test_conflict();
    // both share one slot so the second clashes with the staged entry
    issue(eu_pkg::OP_LOADI, '0, '0, 6'h0c, rand_data());
    issue(eu_pkg::OP_LOADI, '0, '0, 6'h1c, rand_data());
    wait_done();
    check_status(last_done.status, eu_pkg::ST_CONFLICT);
    issue(eu_pkg::OP_LOADI, '0, '0, 6'h2c, rand_data());
    wait_done();
    check_status(last_done.status, eu_pkg::ST_CONFLICT);
    issue(eu_pkg::OP_ADD, 6'h05, 6'h0c, 6'h0f, '0);
    wait_done();
    check_status(last_done.status, eu_pkg::ST_OK);
  endtask

  task automatic test_arith();
    swap_banks();
    issue(eu_pkg::OP_LOADI, '0, '0, 6'h14, rand_data() | 16'hc000);
    issue(eu_pkg::OP_LOADI, '0, '0, 6'h15, rand_data());
    issue(eu_pkg::OP_LOADI, '0, '0, 6'h16, rand_data() & 16'h00ff);
    issue(eu_pkg::OP_LOADI, '0, '0, 6'h17, rand_data());
    wait_done();
    swap_banks();
    issue(eu_pkg::OP_LOADI, '0, '0, 6'h24, rand_data() | 16'hc000);
    issue(eu_pkg::OP_LOADI, '0, '0, 6'h25, rand_data() | 16'hc000);
    wait_done();
    // issued back to back with add and sub forced to wrap
    issue(eu_pkg::OP_ADD, 6'h14, 6'h24, 6'h26, '0);
    issue(eu_pkg::OP_SUB, 6'h16, 6'h25, 6'h27, '0);
    issue(eu_pkg::OP_MUL, 6'h15, 6'h24, 6'h24, '0);
    issue(eu_pkg::OP_ADD, 6'h17, 6'h25, 6'h25, '0);
    wait_done();
    check_status(last_done.status, eu_pkg::ST_OK);
  endtask

  initial begin
    reset_n       = 1'b0;
    instr_i       = '0;
    instr_valid_i = 1'b0;
    swap_i        = 1'b0;
    last_done     = '0;
    m_role        = 0;
    for (int b = 0; b < 2; b++) begin
      for (int i = 0; i < SLOTS; i++) begin
        m_valid[b][i] = 1'b0;
        m_tag[b][i]   = '0;
        m_data[b][i]  = '0;
        m_ready[b][i] = 0;
      end
    end
    repeat (10) @(negedge clk);
    reset_n = 1'b1;

    test_reset_state();
    test_load_forward();
    test_swap();
    test_conflict();
    test_arith();

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
